// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module mem_test_tb
	./obj_dir/Vmem_test_tb | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// ==== hw/block_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_defs.svh"

module block_ram (
    input  logic                clk,
    input  logic                wr_en,
    input  mem_test_pkg::addr_t wr_addr,
    input  mem_test_pkg::word_t wr_data,
    input  mem_test_pkg::addr_t rd_addr,
    output mem_test_pkg::word_t rd_data
);
    import mem_test_pkg::*;

    word_t mem [`MEM_DEPTH];

    // Each word starts out holding its own address.
    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = word_t'(i);
        end
    end

    // Read-first on a same-address collision.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hw/command_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_defs.svh"

module command_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  link_pkg::byte_t     rx_byte,
    input  logic                rx_valid,
    input  logic                busy,
    output logic                wr_en,
    output mem_test_pkg::addr_t wr_addr,
    output mem_test_pkg::word_t wr_data,
    output logic                start
);
    import link_pkg::*;

    dec_state_e state;
    logic [2:0] byte_cnt;
    logic [8*POKE_ADDR_BYTES-1:0] addr_sr;

    assign wr_addr = addr_sr[`MEM_ADDR_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= DEC_IDLE;
            byte_cnt <= '0;
            wr_en    <= 1'b0;
            start    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            start <= 1'b0;
            if (rx_valid) begin
                case (state)
                    DEC_IDLE: begin
                        byte_cnt <= '0;
                        if (rx_byte == CMD_POKE) begin
                            state <= DEC_ADDR;
                        end else if (rx_byte == CMD_START && !busy) begin
                            start <= 1'b1;
                        end
                    end
                    DEC_ADDR: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 3'(POKE_ADDR_BYTES - 1)) begin
                            state    <= DEC_DATA;
                            byte_cnt <= '0;
                        end
                    end
                    default: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        // Last data byte commits the write.
                        if (byte_cnt == 3'(POKE_DATA_BYTES - 1)) begin
                            state <= DEC_IDLE;
                            wr_en <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    // Arguments arrive most significant byte first.
    always_ff @(posedge clk) begin
        if (rx_valid && state == DEC_ADDR) begin
            addr_sr <= {addr_sr[8*POKE_ADDR_BYTES-9:0], rx_byte};
        end
        if (rx_valid && state == DEC_DATA) begin
            wr_data <= {wr_data[`MEM_DATA_W-9:0], rx_byte};
        end
    end

endmodule

`default_nettype wire

// ==== hw/link_pkg.sv ====
`default_nettype none

package link_pkg;

    typedef logic [7:0] byte_t;

    typedef enum byte_t {
        CMD_POKE  = 8'h57,
        CMD_START = 8'h53
    } cmd_e;

    typedef enum byte_t {
        REC_ERROR = 8'h45,
        REC_DONE  = 8'h44
    } rec_e;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_ADDR,
        DEC_DATA
    } dec_state_e;

    // Argument and frame lengths in bytes.
    localparam int unsigned POKE_ADDR_BYTES = 2;
    localparam int unsigned POKE_DATA_BYTES = 4;
    localparam int unsigned ERR_REC_BYTES   = 11;
    localparam int unsigned DONE_REC_BYTES  = 3;

endpackage

`default_nettype wire

// ==== hw/mem_test_pkg.sv ====
`default_nettype none

`include "mem_test_defs.svh"

package mem_test_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_DATA_W-1:0] word_t;

    // Saturates at all ones.
    typedef logic [15:0] err_count_t;

    typedef enum logic [1:0] {
        SWEEP_IDLE,
        SWEEP_RUN,
        SWEEP_HOLD,
        SWEEP_FINISH
    } sweep_state_e;

endpackage

`default_nettype wire

// ==== hw/mem_test_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_test_top (
    input  logic clk,
    input  logic arst_n,
    input  logic rx,
    output logic tx
);
    import mem_test_pkg::*;
    import link_pkg::*;

    byte_t rx_byte;
    logic rx_valid;
    logic wr_en;
    addr_t wr_addr;
    word_t wr_data;
    logic start;
    logic busy;
    addr_t rd_addr;
    word_t rd_data;
    logic err_valid;
    addr_t err_addr;
    word_t err_expected;
    word_t err_actual;
    logic err_taken;
    logic done_valid;
    err_count_t err_count;
    logic done_taken;
    byte_t tx_data;
    logic tx_data_ready;
    logic tx_data_accepted;

    uart_link u_uart_link (
        .clk              (clk),
        .arst_n           (arst_n),
        .rx               (rx),
        .tx               (tx),
        .rx_byte          (rx_byte),
        .rx_valid         (rx_valid),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted)
    );

    command_decode u_command_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .busy     (busy),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .start    (start)
    );

    block_ram u_block_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    sweep_checker u_sweep_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .err_valid    (err_valid),
        .err_addr     (err_addr),
        .err_expected (err_expected),
        .err_actual   (err_actual),
        .err_taken    (err_taken),
        .done_valid   (done_valid),
        .err_count    (err_count),
        .done_taken   (done_taken),
        .busy         (busy)
    );

    report_formatter u_report_formatter (
        .clk              (clk),
        .arst_n           (arst_n),
        .err_valid        (err_valid),
        .err_addr         (err_addr),
        .err_expected     (err_expected),
        .err_actual       (err_actual),
        .err_taken        (err_taken),
        .done_valid       (done_valid),
        .err_count        (err_count),
        .done_taken       (done_taken),
        .tx_data          (tx_data),
        .tx_data_ready    (tx_data_ready),
        .tx_data_accepted (tx_data_accepted)
    );

endmodule

`default_nettype wire

// ==== hw/report_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module report_formatter (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     err_valid,
    input  mem_test_pkg::addr_t      err_addr,
    input  mem_test_pkg::word_t      err_expected,
    input  mem_test_pkg::word_t      err_actual,
    output logic                     err_taken,
    input  logic                     done_valid,
    input  mem_test_pkg::err_count_t err_count,
    output logic                     done_taken,
    output link_pkg::byte_t          tx_data,
    output logic                     tx_data_ready,
    input  logic                     tx_data_accepted
);
    import link_pkg::*;

    localparam int unsigned FRAME_W = 8 * ERR_REC_BYTES;

    logic [FRAME_W-1:0] frame;
    logic [3:0] bytes_left;
    logic idle;
    logic load_err;
    logic load_done;

    assign idle          = (bytes_left == '0);
    assign load_err      = idle && err_valid;
    // Error records win over the summary.
    assign load_done     = idle && !err_valid && done_valid;
    assign tx_data       = frame[FRAME_W-1 -: 8];
    assign tx_data_ready = !idle;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bytes_left <= '0;
            err_taken  <= 1'b0;
            done_taken <= 1'b0;
        end else begin
            err_taken  <= load_err;
            done_taken <= load_done;
            if (load_err) begin
                bytes_left <= 4'(ERR_REC_BYTES);
            end else if (load_done) begin
                bytes_left <= 4'(DONE_REC_BYTES);
            end else if (tx_data_accepted && !idle) begin
                bytes_left <= bytes_left - 1'b1;
            end
        end
    end

    // Frame is left-aligned, the head byte goes out first.
    always_ff @(posedge clk) begin
        if (load_err) begin
            frame <= {byte_t'(REC_ERROR), 16'(err_addr), err_expected, err_actual};
        end else if (load_done) begin
            frame <= {byte_t'(REC_DONE), err_count, {(FRAME_W - 24){1'b0}}};
        end else if (tx_data_accepted) begin
            frame <= {frame[FRAME_W-9:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

// ==== hw/sweep_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_defs.svh"

module sweep_checker (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    output mem_test_pkg::addr_t      rd_addr,
    input  mem_test_pkg::word_t      rd_data,
    output logic                     err_valid,
    output mem_test_pkg::addr_t      err_addr,
    output mem_test_pkg::word_t      err_expected,
    output mem_test_pkg::word_t      err_actual,
    input  logic                     err_taken,
    output logic                     done_valid,
    output mem_test_pkg::err_count_t err_count,
    input  logic                     done_taken,
    output logic                     busy
);
    import mem_test_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(`MEM_DEPTH - 1);

    sweep_state_e state;
    logic issue_vld;
    logic cmp_vld;
    addr_t cmp_addr;
    word_t pattern;
    logic mismatch;

    // Expected word is the address, zero-extended.
    assign pattern  = word_t'(cmp_addr);
    assign mismatch = cmp_vld && (rd_data != pattern);
    assign busy     = (state != SWEEP_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= SWEEP_IDLE;
            rd_addr    <= '0;
            issue_vld  <= 1'b0;
            cmp_vld    <= 1'b0;
            err_valid  <= 1'b0;
            done_valid <= 1'b0;
            err_count  <= '0;
        end else begin
            // A mismatch discards the read behind it.
            cmp_vld <= issue_vld && !mismatch;
            case (state)
                SWEEP_IDLE: begin
                    if (start) begin
                        state     <= SWEEP_RUN;
                        rd_addr   <= '0;
                        issue_vld <= 1'b1;
                        err_count <= '0;
                    end
                end
                SWEEP_RUN: begin
                    if (mismatch) begin
                        // rd_addr already points at the discarded read.
                        state     <= SWEEP_HOLD;
                        issue_vld <= 1'b0;
                        err_valid <= 1'b1;
                        if (err_count != '1) begin
                            err_count <= err_count + 1'b1;
                        end
                    end else if (cmp_vld && cmp_addr == LAST_ADDR) begin
                        state      <= SWEEP_FINISH;
                        done_valid <= 1'b1;
                    end else if (issue_vld) begin
                        if (rd_addr == LAST_ADDR) begin
                            issue_vld <= 1'b0;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
                SWEEP_HOLD: begin
                    if (err_taken) begin
                        err_valid <= 1'b0;
                        if (err_addr == LAST_ADDR) begin
                            state      <= SWEEP_FINISH;
                            done_valid <= 1'b1;
                        end else begin
                            state     <= SWEEP_RUN;
                            issue_vld <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (done_taken) begin
                        state      <= SWEEP_IDLE;
                        done_valid <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cmp_addr <= rd_addr;
        if (mismatch) begin
            err_addr     <= cmp_addr;
            err_expected <= pattern;
            err_actual   <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_link.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_defs.svh"

module uart_link (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rx,
    output logic            tx,
    output link_pkg::byte_t rx_byte,
    output logic            rx_valid,
    input  link_pkg::byte_t tx_data,
    input  logic            tx_data_ready,
    output logic            tx_data_accepted
);
    import link_pkg::*;

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END = CNT_W'(`CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] BIT_MID = CNT_W'(`CLKS_PER_BIT / 2 - 1);

    logic [1:0] rx_sync;
    logic rx_s;
    logic rx_busy;
    logic [CNT_W-1:0] rx_cnt;
    logic [3:0] rx_bit;
    byte_t rx_sr;

    logic tx_busy;
    logic [CNT_W-1:0] tx_cnt;
    logic [3:0] tx_bit;
    logic [9:0] tx_sr;

    assign rx_s    = rx_sync[1];
    assign rx_byte = rx_sr;
    assign tx      = tx_sr[0];

    // Receiver. Bit 0 is the start bit, bit 9 the stop bit.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync  <= 2'b11;
            rx_busy  <= 1'b0;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            if (!rx_busy) begin
                if (!rx_s) begin
                    rx_busy <= 1'b1;
                    rx_cnt  <= '0;
                    rx_bit  <= '0;
                end
            end else begin
                rx_cnt <= (rx_cnt == BIT_END) ? '0 : rx_cnt + 1'b1;
                if (rx_cnt == BIT_END) begin
                    rx_bit <= rx_bit + 1'b1;
                end
                if (rx_cnt == BIT_MID) begin
                    if (rx_bit == 4'd0 && rx_s) begin
                        rx_busy <= 1'b0;  // start glitch
                    end else if (rx_bit == 4'd9) begin
                        rx_busy  <= 1'b0;
                        rx_valid <= rx_s;
                    end
                end
            end
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (rx_busy && rx_cnt == BIT_MID && rx_bit != 4'd0 && rx_bit != 4'd9) begin
            rx_sr <= {rx_s, rx_sr[7:1]};
        end
    end

    // Transmitter.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_busy          <= 1'b0;
            tx_cnt           <= '0;
            tx_bit           <= '0;
            tx_sr            <= '1;
            tx_data_accepted <= 1'b0;
        end else begin
            tx_data_accepted <= 1'b0;
            if (!tx_busy) begin
                if (tx_data_ready) begin
                    tx_sr            <= {1'b1, tx_data, 1'b0};
                    tx_busy          <= 1'b1;
                    tx_cnt           <= '0;
                    tx_bit           <= '0;
                    tx_data_accepted <= 1'b1;
                end
            end else if (tx_cnt == BIT_END) begin
                tx_cnt <= '0;
                tx_sr  <= {1'b1, tx_sr[9:1]};
                if (tx_bit == 4'd9) begin
                    tx_busy <= 1'b0;
                end else begin
                    tx_bit <= tx_bit + 1'b1;
                end
            end else begin
                tx_cnt <= tx_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== include/mem_test_defs.svh ====
`ifndef MEM_TEST_DEFS_SVH
`define MEM_TEST_DEFS_SVH

// Memory under test.
`define MEM_ADDR_W 9
`define MEM_DATA_W 32
`define MEM_DEPTH 512

// Serial bit time in clocks.
`define CLKS_PER_BIT 8

`endif

// ==== sim.f ====
+incdir+include
hw/mem_test_pkg.sv
hw/link_pkg.sv
hw/block_ram.sv
hw/command_decode.sv
hw/sweep_checker.sv
hw/report_formatter.sv
hw/uart_link.sv
hw/mem_test_top.sv
test/sweep_checker_assertions.sv
test/mem_test_checker.sv
test/mem_test_tb.sv

// ==== test/mem_test_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_defs.svh"

module mem_test_checker (
    input  logic clk,
    input  logic arst_n,
    input  logic rx,
    input  logic tx,
    output int   reports_done,
    output int   error_count
);
    import mem_test_pkg::*;
    import link_pkg::*;

    word_t mirror [`MEM_DEPTH];
    byte_t expected_q [$];
    logic in_poke;
    int unsigned arg_cnt;
    logic [15:0] poke_addr;
    word_t poke_data;
    logic pass_busy;
    int unsigned frame_left;
    logic in_summary;

    function automatic void push_msb_first(input logic [31:0] value, input int nbytes);
        for (int k = nbytes - 1; k >= 0; k--) begin
            expected_q.push_back(value[8*k +: 8]);
        end
    endfunction

    // Reference report. One record per word that differs from its address, then the count.
    function automatic void build_expected();
        int unsigned errs;
        errs = 0;
        expected_q.delete();
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            if (mirror[a] != word_t'(a)) begin
                expected_q.push_back(REC_ERROR);
                push_msb_first(32'(a), 2);
                push_msb_first(32'(a), 4);
                push_msb_first(mirror[a], 4);
                if (errs < 32'hffff) begin
                    errs++;
                end
            end
        end
        expected_q.push_back(REC_DONE);
        push_msb_first(errs, 2);
    endfunction

    task automatic take_command_byte(input byte_t b);
        if (in_poke) begin
            if (arg_cnt < 2) begin
                poke_addr = {poke_addr[7:0], b};
            end else begin
                poke_data = {poke_data[23:0], b};
            end
            arg_cnt++;
            if (arg_cnt == 6) begin
                mirror[poke_addr[`MEM_ADDR_W-1:0]] = poke_data;
                in_poke = 1'b0;
            end
        end else if (b == CMD_POKE) begin
            in_poke = 1'b1;
            arg_cnt = 0;
        end else if (b == CMD_START && !pass_busy) begin
            pass_busy = 1'b1;
            build_expected();
        end
    endtask

    task automatic close_report();
        if (expected_q.size() != 0) begin
            $display("%0t: report ended with %0d expected bytes never sent",
                     $time, expected_q.size());
            error_count += expected_q.size();
            expected_q.delete();
        end
        reports_done++;
    endtask

    task automatic take_report_byte(input byte_t b);
        byte_t want;
        if (expected_q.size() == 0) begin
            $display("%0t: tx sent byte %h while no report byte was expected", $time, b);
            error_count++;
        end else begin
            want = expected_q.pop_front();
            if (b !== want) begin
                $display("[FAIL] %0t tx_byte expected %h actual %h", $time, want, b);
                error_count++;
            end
        end
        // Frame tracking marks the end of a report.
        if (frame_left > 0) begin
            frame_left--;
            if (frame_left == 0 && in_summary) begin
                in_summary = 1'b0;
                close_report();
            end
        end else if (b == REC_ERROR) begin
            frame_left = 10;
        end else if (b == REC_DONE) begin
            frame_left = 2;
            in_summary = 1'b1;
            pass_busy = 1'b0;
        end else begin
            $display("%0t: tx frame started with unknown tag %h", $time, b);
            error_count++;
        end
    endtask

    initial begin : rx_watch
        byte_t b;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mirror[i] = word_t'(i);
        end
        in_poke = 1'b0;
        arg_cnt = 0;
        pass_busy = 1'b0;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge rx);
            repeat (`CLKS_PER_BIT / 2) @(posedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (`CLKS_PER_BIT) @(posedge clk);
                b[i] = rx;
            end
            repeat (`CLKS_PER_BIT) @(posedge clk);
            take_command_byte(b);
        end
    end

    initial begin : tx_watch
        byte_t b;
        reports_done = 0;
        error_count = 0;
        frame_left = 0;
        in_summary = 1'b0;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge tx);
            repeat (`CLKS_PER_BIT / 2) @(posedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (`CLKS_PER_BIT) @(posedge clk);
                b[i] = tx;
            end
            repeat (`CLKS_PER_BIT) @(posedge clk);
            take_report_byte(b);
        end
    end

endmodule

`default_nettype wire

// ==== test/mem_test_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_defs.svh"

module mem_test_tb;
    import mem_test_pkg::*;
    import link_pkg::*;

    localparam int N_TESTS = 5;
    localparam int MAX_RECORDS = 3;
    // Worst case pass with every byte at UART speed, doubled.
    localparam int WATCHDOG_CYCLES =
        2 * N_TESTS * (`MEM_DEPTH + MAX_RECORDS * 11 + 3) * 10 * `CLKS_PER_BIT;

    logic clk;
    logic arst_n;
    logic rx;
    logic tx;
    int reports_done;
    int check_errors;
    int seed;
    int tests_passed;
    int tests_failed;
    int errors_before;
    addr_t rand_addr;
    addr_t mid_addr;
    word_t rand_data;

    mem_test_top u_mem_test_top (
        .clk    (clk),
        .arst_n (arst_n),
        .rx     (rx),
        .tx     (tx)
    );

    mem_test_checker u_mem_test_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .rx           (rx),
        .tx           (tx),
        .reports_done (reports_done),
        .error_count  (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles while waiting for a report", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    function automatic int total_errors();
        return check_errors + u_mem_test_top.u_sweep_checker.u_sweep_checker_assertions.fail_cnt;
    endfunction

    // 8N1, LSB first.
    task automatic send_byte(input byte_t b);
        @(negedge clk);
        rx = 1'b0;
        repeat (`CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = b[i];
            repeat (`CLKS_PER_BIT) @(negedge clk);
        end
        rx = 1'b1;
        repeat (`CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_poke(input addr_t addr, input word_t data);
        logic [15:0] a16;
        a16 = 16'(addr);
        send_byte(CMD_POKE);
        send_byte(a16[15:8]);
        send_byte(a16[7:0]);
        for (int k = 3; k >= 0; k--) begin
            send_byte(data[8*k +: 8]);
        end
    endtask

    // Extra starts land while the pass is still running.
    task automatic run_pass(input int extra_starts);
        int seen;
        seen = reports_done;
        send_byte(CMD_START);
        repeat (extra_starts) send_byte(CMD_START);
        wait (reports_done != seen);
    endtask

    // A stray pass would put report bytes on tx within this window.
    task automatic wait_quiet_window();
        repeat (`MEM_DEPTH + 4 * 10 * `CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = total_errors() - errors_before;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
        errors_before = total_errors();
    endtask

    initial begin
        seed = 32'h1f633a83;
        arst_n = 1'b0;
        rx = 1'b1;
        tests_passed = 0;
        tests_failed = 0;
        errors_before = 0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) @(negedge clk);

        run_pass(0);
        finish_test("1 clean pass after reset");

        rand_addr = addr_t'($random(seed));
        rand_data = word_t'($random(seed));
        if (rand_data == word_t'(rand_addr)) begin
            rand_data = ~rand_data;
        end
        send_poke(rand_addr, rand_data);
        run_pass(0);
        finish_test("2 one corrupted word");

        mid_addr = addr_t'(1 + ($unsigned($random(seed)) % (`MEM_DEPTH - 2)));
        send_poke(rand_addr, word_t'(rand_addr));
        send_poke(addr_t'(0), 32'hdead_beef);
        send_poke(addr_t'(`MEM_DEPTH - 1), 32'h0000_0000);
        send_poke(mid_addr, ~word_t'(mid_addr));
        run_pass(0);
        finish_test("3 first, middle and last words");

        send_poke(addr_t'(0), word_t'(0));
        send_poke(addr_t'(`MEM_DEPTH - 1), word_t'(`MEM_DEPTH - 1));
        send_poke(mid_addr, word_t'(mid_addr));
        run_pass(0);
        finish_test("4 pattern restored");

        send_byte(8'h41);
        send_byte(8'hff);
        wait_quiet_window();
        run_pass(1);
        wait_quiet_window();
        run_pass(0);
        finish_test("5 unknown opcodes and start while busy");

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/sweep_checker_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module sweep_checker_assertions (
    input logic                clk,
    input logic                arst_n,
    input mem_test_pkg::addr_t rd_addr,
    input logic                err_valid,
    input mem_test_pkg::addr_t err_addr,
    input mem_test_pkg::word_t err_expected,
    input mem_test_pkg::word_t err_actual,
    input logic                err_taken,
    input logic                done_taken,
    input logic                busy
);
    int fail_cnt = 0;

    // Record stays put until the formatter takes it.
    err_held: assert property (@(posedge clk) disable iff (!arst_n)
        err_valid && !err_taken |=>
            err_valid && $stable({err_addr, err_expected, err_actual}))
        else begin
            fail_cnt++;
            $error("error record changed or dropped before err_taken");
        end

    // Sweep is frozen while a record waits.
    addr_frozen: assert property (@(posedge clk) disable iff (!arst_n)
        err_valid |-> $stable(rd_addr))
        else begin
            fail_cnt++;
            $error("rd_addr moved while err_valid was high");
        end

    busy_release: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(done_taken))
        else begin
            fail_cnt++;
            $error("busy fell without done_taken");
        end

endmodule

bind sweep_checker sweep_checker_assertions u_sweep_checker_assertions (
    .clk          (clk),
    .arst_n       (arst_n),
    .rd_addr      (rd_addr),
    .err_valid    (err_valid),
    .err_addr     (err_addr),
    .err_expected (err_expected),
    .err_actual   (err_actual),
    .err_taken    (err_taken),
    .done_taken   (done_taken),
    .busy         (busy)
);

`default_nettype wire
